/* rtl/audio_pkg.sv */
package audio_pkg;

    ////////////////////////////////////////////////////////////
    // Sample and control types
    ////////////////////////////////////////////////////////////

    typedef logic signed [15:0] sample_t;   // One output word
    typedef logic signed [16:0] wide_t;     // One bit of mix headroom
    typedef logic signed [10:0] tandy_t;    // Tandy PSG DAC word
    typedef logic [1:0]         volume_t;   // Each step doubles the level

    // Code 3 is not named but selects curve 2 as well
    typedef enum logic [1:0]
    {
        comp_off    = 2'd0,
        comp_gentle = 2'd1,
        comp_strong = 2'd2
    } compress_mode_t;

    typedef enum logic
    {
        chan_left  = 1'b0,
        chan_right = 1'b1
    } channel_t;

    ////////////////////////////////////////////////////////////
    // Levels
    ////////////////////////////////////////////////////////////

    localparam int      FULL_SCALE   = 32767;
    localparam sample_t SAMPLE_MAX   = 16'sh7fff;
    localparam sample_t SAMPLE_MIN   = 16'sh8000;
    localparam int      SPEAKER_UNIT = 2048;      // Speaker step at volume 0

    ////////////////////////////////////////////////////////////
    // Compressor curves
    ////////////////////////////////////////////////////////////

    // Gentle curve, x2 below the knee
    localparam int COMP1_FACTOR = 4;
    localparam int COMP1_GAIN   = 2;
    localparam int COMP1_KNEE   =
        ((FULL_SCALE * (COMP1_FACTOR - 1)) / ((COMP1_FACTOR * COMP1_GAIN) - 1)) + 1;
    localparam int COMP1_BASE   = COMP1_KNEE * COMP1_GAIN;

    // Strong curve, x4 below the knee
    localparam int COMP2_FACTOR = 8;
    localparam int COMP2_GAIN   = 4;
    localparam int COMP2_KNEE   =
        ((FULL_SCALE * (COMP2_FACTOR - 1)) / ((COMP2_FACTOR * COMP2_GAIN) - 1)) + 1;
    localparam int COMP2_BASE   = COMP2_KNEE * COMP2_GAIN;

    // Knee is rounded up by one so the lower segment never overshoots

endpackage

/* rtl/mix_sources_if.sv */
interface mix_sources_if;
    import audio_pkg::*;

    // Every contribution is already in mixing width
    wide_t opl;         // OPL2 FM
    wide_t cms_left;    // C/MS left
    wide_t cms_right;   // C/MS right
    wide_t tandy;       // PSG after volume
    wide_t speaker;     // Beeper after volume

    // Conditioner side
    modport source
    (
        output opl,
        output cms_left,
        output cms_right,
        output tandy,
        output speaker
    );

    // Per-channel mixers, both read the shared words
    modport mixer
    (
        input opl,
        input cms_left,
        input cms_right,
        input tandy,
        input speaker
    );

endinterface

/* rtl/audio_source_conditioner.sv */
module audio_source_conditioner
(
    input  audio_pkg::sample_t opl_sample,
    input  audio_pkg::sample_t cms_left,
    input  audio_pkg::sample_t cms_right,
    input  audio_pkg::tandy_t  tandy_sample,
    input  logic               speaker_level,
    input  audio_pkg::volume_t speaker_volume,
    input  audio_pkg::volume_t tandy_volume,
    mix_sources_if.source      sources
);
    import audio_pkg::*;

    logic signed [14:0] tandy_ext;      // Room for three volume shifts
    logic signed [14:0] tandy_scaled;
    wide_t              speaker_scaled;

    ////////////////////////////////////////////////////////////
    // 16-bit sources
    ////////////////////////////////////////////////////////////

    // Plain sign extension, no gain
    assign sources.opl       = {opl_sample[15], opl_sample};
    assign sources.cms_left  = {cms_left[15], cms_left};
    assign sources.cms_right = {cms_right[15], cms_right};

    ////////////////////////////////////////////////////////////
    // Tandy PSG
    ////////////////////////////////////////////////////////////

    assign tandy_ext    = {{4{tandy_sample[10]}}, tandy_sample};
    assign tandy_scaled = tandy_ext <<< tandy_volume;  // x1 .. x8

    // Fixed x4 on top of the volume step
    assign sources.tandy = {tandy_scaled, 2'b00};

    ////////////////////////////////////////////////////////////
    // PC speaker
    ////////////////////////////////////////////////////////////

    // The speaker pin idles high, so a low level is the active half
    assign speaker_scaled = wide_t'(SPEAKER_UNIT) << speaker_volume;   // 2048 .. 16384

    assign sources.speaker = speaker_level ? '0 : speaker_scaled;

endmodule

/* rtl/audio_mix_clamp.sv */
module audio_mix_clamp
#(
    parameter audio_pkg::channel_t SIDE = audio_pkg::chan_left
)
(
    input  logic               clk_chipset,
    input  logic               reset,
    mix_sources_if.mixer       sources,
    output audio_pkg::sample_t mixed
);
    import audio_pkg::*;

    wide_t   cms_word;
    wide_t   sum_next;
    wide_t   sum;           // Stage 1
    logic    overflow;
    sample_t clamped;

    ////////////////////////////////////////////////////////////
    // Stage 1, channel sum
    ////////////////////////////////////////////////////////////

    // Only C/MS differs between the two sides
    assign cms_word = (SIDE == chan_left) ? sources.cms_left : sources.cms_right;

    assign sum_next = sources.opl + cms_word + sources.tandy + sources.speaker;

    always_ff @(posedge clk_chipset or posedge reset)
    begin
        if (reset)
            sum <= '0;
        else
            sum <= sum_next;
    end

    ////////////////////////////////////////////////////////////
    // Stage 2, saturation
    ////////////////////////////////////////////////////////////

    // Top two bits disagree when the sum left the 16-bit range
    assign overflow = sum[16] ^ sum[15];

    always_comb
    begin
        if (!overflow)
            clamped = sum[15:0];
        else if (sum[16])
            clamped = SAMPLE_MIN;      // Negative overflow
        else
            clamped = SAMPLE_MAX;
    end

    always_ff @(posedge clk_chipset or posedge reset)
    begin
        if (reset)
            mixed <= '0;
        else
            mixed <= clamped;
    end

endmodule

/* rtl/audio_compressor.sv */
module audio_compressor
(
    input  logic                      clk_chipset,
    input  logic                      reset,
    input  audio_pkg::sample_t        mixed,
    input  audio_pkg::compress_mode_t compress_mode,
    input  logic                      pause,
    output audio_pkg::sample_t        audio
);
    import audio_pkg::*;

    wide_t       mixed_ext;
    logic [16:0] magnitude;        // Holds 32768 for the most negative input
    logic [16:0] curve_gentle;
    logic [16:0] curve_strong;
    logic [16:0] curve_sel;
    logic [16:0] level;
    sample_t     level_word;
    sample_t     compressed_next;
    sample_t     compressed;

    // Two-segment curve on a magnitude
    function automatic logic [16:0] apply_curve
    (
        input logic [16:0] mag,
        input int          knee,
        input int          gain,
        input int          factor,
        input int          base
    );
        logic [16:0] result;

        if (mag < 17'(knee))
            result = 17'(mag * gain);                          // Boost quiet part
        else
            result = 17'(((mag - 17'(knee)) / factor) + base); // Flatten loud part
        return result;
    endfunction

    ////////////////////////////////////////////////////////////
    // Magnitude and curves
    ////////////////////////////////////////////////////////////

    assign mixed_ext = {mixed[15], mixed};
    assign magnitude = mixed[15] ? -mixed_ext : mixed_ext;

    assign curve_gentle = apply_curve(magnitude, COMP1_KNEE, COMP1_GAIN,
                                      COMP1_FACTOR, COMP1_BASE);
    assign curve_strong = apply_curve(magnitude, COMP2_KNEE, COMP2_GAIN,
                                      COMP2_FACTOR, COMP2_BASE);

    // Bit 1 set means curve 2, codes 2 and 3
    assign curve_sel = compress_mode[1] ? curve_strong : curve_gentle;

    // Upper segment ends a few counts past full scale
    assign level      = (curve_sel > 17'(FULL_SCALE)) ? 17'(FULL_SCALE) : curve_sel;
    assign level_word = level[15:0];

    assign compressed_next = mixed[15] ? -level_word : level_word;  // Restore sign

    always_ff @(posedge clk_chipset or posedge reset)
    begin
        if (reset)
            compressed <= '0;
        else
            compressed <= compressed_next;
    end

    ////////////////////////////////////////////////////////////
    // Output select
    ////////////////////////////////////////////////////////////

    always_comb
    begin
        if (pause)
            audio = '0;                 // Silence while paused
        else if (compress_mode == comp_off)
            audio = mixed;              // Bypass, no extra cycle
        else
            audio = compressed;
    end

endmodule

/* rtl/audio_mixer_top.sv */
module audio_mixer_top
(
    input  logic                      clk_chipset,
    input  logic                      reset,
    input  audio_pkg::sample_t        opl_sample,
    input  audio_pkg::sample_t        cms_left,
    input  audio_pkg::sample_t        cms_right,
    input  audio_pkg::tandy_t         tandy_sample,
    input  logic                      speaker_level,
    input  audio_pkg::volume_t        speaker_volume,
    input  audio_pkg::volume_t        tandy_volume,
    input  audio_pkg::compress_mode_t compress_mode,
    input  logic                      pause,
    output audio_pkg::sample_t        audio_left,
    output audio_pkg::sample_t        audio_right
);
    import audio_pkg::*;

    sample_t mixed_left;     // Clamped, two cycles after the inputs
    sample_t mixed_right;

    mix_sources_if sources();

    ////////////////////////////////////////////////////////////
    // Source conditioning
    ////////////////////////////////////////////////////////////

    audio_source_conditioner u_conditioner
    (
        .opl_sample     (opl_sample),
        .cms_left       (cms_left),
        .cms_right      (cms_right),
        .tandy_sample   (tandy_sample),
        .speaker_level  (speaker_level),
        .speaker_volume (speaker_volume),
        .tandy_volume   (tandy_volume),
        .sources        (sources.source)
    );

    ////////////////////////////////////////////////////////////
    // Channel mixers
    ////////////////////////////////////////////////////////////

    audio_mix_clamp #(.SIDE(chan_left)) u_mix_left
    (
        .clk_chipset (clk_chipset),
        .reset       (reset),
        .sources     (sources.mixer),
        .mixed       (mixed_left)
    );

    audio_mix_clamp #(.SIDE(chan_right)) u_mix_right
    (
        .clk_chipset (clk_chipset),
        .reset       (reset),
        .sources     (sources.mixer),
        .mixed       (mixed_right)
    );

    ////////////////////////////////////////////////////////////
    // Output stage
    ////////////////////////////////////////////////////////////

    audio_compressor u_comp_left
    (
        .clk_chipset   (clk_chipset),
        .reset         (reset),
        .mixed         (mixed_left),
        .compress_mode (compress_mode),
        .pause         (pause),
        .audio         (audio_left)
    );

    audio_compressor u_comp_right
    (
        .clk_chipset   (clk_chipset),
        .reset         (reset),
        .mixed         (mixed_right),
        .compress_mode (compress_mode),
        .pause         (pause),
        .audio         (audio_right)
    );

endmodule

/* bench/audio_mixer_tb.sv */
module audio_mixer_tb;
    timeunit 1ns;
    timeprecision 1ps;

    import audio_pkg::*;

    localparam int    RESET_CYCLES = 5;
    localparam int    HOLD_CYCLES  = 4;      // Longest path is 3 cycles
    localparam int    MAX_LINES    = 1000;   // Bound on the vector file loop
    localparam string VECTOR_FILE  = "bench/audio_mixer_tests.txt";

    logic           clk_chipset;
    logic           reset;
    sample_t        opl_sample;
    sample_t        cms_left;
    sample_t        cms_right;
    tandy_t         tandy_sample;
    logic           speaker_level;
    volume_t        speaker_volume;
    volume_t        tandy_volume;
    compress_mode_t compress_mode;
    logic           pause;
    sample_t        audio_left;
    sample_t        audio_right;

    int errors;
    int checks;
    int vectors;

    audio_mixer_top uut
    (
        .clk_chipset    (clk_chipset),
        .reset          (reset),
        .opl_sample     (opl_sample),
        .cms_left       (cms_left),
        .cms_right      (cms_right),
        .tandy_sample   (tandy_sample),
        .speaker_level  (speaker_level),
        .speaker_volume (speaker_volume),
        .tandy_volume   (tandy_volume),
        .compress_mode  (compress_mode),
        .pause          (pause),
        .audio_left     (audio_left),
        .audio_right    (audio_right)
    );

    ////////////////////////////////////////////////////////////
    // Clock
    ////////////////////////////////////////////////////////////

    initial
    begin
        clk_chipset = 1'b0;
        forever #4 clk_chipset = ~clk_chipset;   // 8 ns period
    end

    ////////////////////////////////////////////////////////////
    // Helpers
    ////////////////////////////////////////////////////////////

    task automatic check_value(input string test_name, input string port_name,
                               input sample_t expected, input sample_t actual);
        checks++;
        if (actual !== expected)
        begin
            errors++;
            $display("MISMATCH %s %s expected %0d actual %0d",
                     test_name, port_name, expected, actual);
        end
    endtask

    // Counts rising edges
    task automatic wait_clocks(input int count);
        for (int i = 0; i < count; i++)
            @(posedge clk_chipset);
    endtask

    // Skips comment lines and blank lines
    function automatic bit skip_line(input string s);
        if (s.len() == 0)
            return 1'b1;
        return (s.getc(0) == "#") || (s.getc(0) == "\n") || (s.getc(0) == "\r");
    endfunction

    task automatic run_vector(input string name, input int opl, input int cms_l,
                              input int cms_r, input int tandy, input int spk_level,
                              input int spk_vol, input int tandy_vol, input int mode,
                              input int pause_val, input int exp_left, input int exp_right);
        @(posedge clk_chipset);
        opl_sample     <= sample_t'(opl);
        cms_left       <= sample_t'(cms_l);
        cms_right      <= sample_t'(cms_r);
        tandy_sample   <= tandy_t'(tandy);
        speaker_level  <= spk_level[0];
        speaker_volume <= volume_t'(spk_vol);
        tandy_volume   <= volume_t'(tandy_vol);
        compress_mode  <= compress_mode_t'(mode[1:0]);
        pause          <= pause_val[0];

        wait_clocks(HOLD_CYCLES);
        @(negedge clk_chipset);     // Outputs settled
        check_value(name, "audio_left", sample_t'(exp_left), audio_left);
        check_value(name, "audio_right", sample_t'(exp_right), audio_right);
    endtask

    ////////////////////////////////////////////////////////////
    // Main sequence
    ////////////////////////////////////////////////////////////

    initial
    begin
        int    fd;
        int    got;
        int    fields;
        int    lines_read;
        string line;
        string name;
        int    v_opl, v_cms_l, v_cms_r, v_tandy, v_spk_level;
        int    v_spk_vol, v_tandy_vol, v_mode, v_pause, v_left, v_right;

        errors     = 0;
        checks     = 0;
        vectors    = 0;
        lines_read = 0;

        reset          = 1'b1;
        opl_sample     = '0;
        cms_left       = '0;
        cms_right      = '0;
        tandy_sample   = '0;
        speaker_level  = 1'b1;        // Speaker silent
        speaker_volume = '0;
        tandy_volume   = '0;
        compress_mode  = comp_off;
        pause          = 1'b0;

        // Outputs must stay at zero through reset
        for (int i = 0; i < RESET_CYCLES; i++)
        begin
            @(negedge clk_chipset);
            check_value("reset", "audio_left", '0, audio_left);
            check_value("reset", "audio_right", '0, audio_right);
        end
        @(posedge clk_chipset);
        reset <= 1'b0;

        for (int i = 0; i < 2; i++)
        begin
            @(negedge clk_chipset);
            check_value("after_reset", "audio_left", '0, audio_left);
            check_value("after_reset", "audio_right", '0, audio_right);
        end

        fd = $fopen(VECTOR_FILE, "r");
        if (fd == 0)
        begin
            errors++;
            $display("Could not open the test vector file %s", VECTOR_FILE);
        end
        else
        begin
            while (!$feof(fd) && (lines_read < MAX_LINES))
            begin
                line = "";
                got  = $fgets(line, fd);
                lines_read++;
                if ((got > 0) && !skip_line(line))
                begin
                    fields = $sscanf(line, "%s %h %h %h %h %h %h %h %h %h %h %h", name,
                                     v_opl, v_cms_l, v_cms_r, v_tandy, v_spk_level,
                                     v_spk_vol, v_tandy_vol, v_mode, v_pause,
                                     v_left, v_right);
                    if (fields != 12)
                    begin
                        errors++;
                        $display("Vector line %0d could not be parsed", lines_read);
                    end
                    else
                    begin
                        vectors++;
                        run_vector(name, v_opl, v_cms_l, v_cms_r, v_tandy, v_spk_level,
                                   v_spk_vol, v_tandy_vol, v_mode, v_pause,
                                   v_left, v_right);
                    end
                end
            end
            if (lines_read >= MAX_LINES)
            begin
                errors++;
                $display("Vector file is longer than %0d lines, reading stopped", MAX_LINES);
            end
            $fclose(fd);
            if (vectors == 0)
            begin
                errors++;
                $display("The vector file held no test vectors");
            end
        end

        $display("Vectors %0d, checks %0d, errors %0d", vectors, checks, errors);
        if (errors == 0)
            $display("Test passed");
        else
            $display("Test failed");
        $finish;
    end

endmodule

/* bench/audio_mixer_tests.txt */
# name opl cms_left cms_right tandy spk_level spk_vol tandy_vol mode pause exp_left exp_right
# All values hex, tandy is 11 bits, samples are 16-bit two's complement
mix_opl          03E8 0000 0000 000 1 0 0 0 0 03E8 03E8
mix_cms_split    0100 0200 FED4 000 1 0 0 0 0 0300 FFD4
mix_tandy        0000 0000 0000 064 1 0 0 0 0 0190 0190
mix_all          FC18 07D0 F830 7CE 0 0 1 0 0 0A58 FAB8
sat_pos          6000 4000 3000 000 1 0 0 0 0 7FFF 7FFF
sat_neg          A000 C000 D000 000 1 0 0 0 0 8000 8000
sat_split        7000 2000 E000 000 1 0 0 0 0 7FFF 5000
spk_vol0         0000 0000 0000 000 0 0 0 0 0 0800 0800
spk_vol1         0000 0000 0000 000 0 1 0 0 0 1000 1000
spk_vol2         0000 0000 0000 000 0 2 0 0 0 2000 2000
spk_vol3         0000 0000 0000 000 0 3 0 0 0 4000 4000
spk_high_vol3    0000 0000 0000 000 1 3 0 0 0 0000 0000
tandy_vol0       0000 0000 0000 064 1 0 0 0 0 0190 0190
tandy_vol1       0000 0000 0000 064 1 0 1 0 0 0320 0320
tandy_vol2       0000 0000 0000 064 1 0 2 0 0 0640 0640
tandy_vol3       0000 0000 0000 064 1 0 3 0 0 0C80 0C80
tandy_neg_vol3   0000 0000 0000 400 1 0 3 0 0 8000 8000
tandy_max_vol3   0000 0000 0000 3FF 1 0 3 0 0 7FE0 7FE0
gentle_low       0000 1388 EC78 000 1 0 0 1 0 2710 D8F0
gentle_high      0000 4E20 B1E0 000 1 0 0 1 0 7389 8C77
gentle_knee      0000 36DB 36DC 000 1 0 0 1 0 6DB6 6DB8
gentle_trunc     0000 C921 36E3 000 1 0 0 1 0 9248 6DB9
strong_low       0000 03E8 E319 000 1 0 0 2 0 0FA0 8C64
strong_high      0000 3E80 8AD0 000 1 0 0 2 0 77D3 8157
strong_mode3     0000 1CE8 0064 000 1 0 0 3 0 73A0 0190
pause_on         03E8 0200 0300 000 0 0 0 0 1 0000 0000
pause_off        03E8 0200 0300 000 0 0 0 0 0 0DE8 0EE8
pause_comp_on    03E8 0200 0300 000 0 0 0 1 1 0000 0000
pause_comp_off   03E8 0200 0300 000 0 0 0 1 0 1BD0 1DD0
zero_end         0000 0000 0000 000 1 0 0 0 0 0000 0000

/* verilog.f */
rtl/audio_pkg.sv
rtl/mix_sources_if.sv
rtl/audio_source_conditioner.sv
rtl/audio_mix_clamp.sv
rtl/audio_compressor.sv
rtl/audio_mixer_top.sv
bench/audio_mixer_tb.sv

/* Bender.yml */
package:
  name: audio_mixer

sources:
  - rtl/audio_pkg.sv
  - rtl/mix_sources_if.sv
  - rtl/audio_source_conditioner.sv
  - rtl/audio_mix_clamp.sv
  - rtl/audio_compressor.sv
  - rtl/audio_mixer_top.sv
  - target: test
    files:
      - bench/audio_mixer_tb.sv
